// File: source/zc_seq_pkg.sv
package zc_seq_pkg;

  ////////////////////
  // Basic types
  ////////////////////

  typedef logic [31:0] instr_word_t;

  // Kind of compressed word seen by the sequencer
  typedef enum logic [2:0] {
    INVALID_INST,
    PUSH,
    POP,
    POPRET,
    POPRETZ,
    MVSA01,
    MVA01S
  } seq_instr_e;

  // Expansion steps of the push/pop/move sequences
  typedef enum logic [2:0] {
    S_IDLE,
    S_PUSH,
    S_POP,
    S_RA,
    S_SP,
    S_A0,
    S_RET,
    S_DMOVE
  } seq_state_e;

  ////////////////////
  // RV32I encodings
  ////////////////////

  localparam logic [6:0] OPCODE_LOAD  = 7'h03;
  localparam logic [6:0] OPCODE_STORE = 7'h23;
  localparam logic [6:0] OPCODE_OPIMM = 7'h13;
  localparam logic [6:0] OPCODE_JALR  = 7'h67;

  localparam logic [4:0] REG_ZERO = 5'd0;
  localparam logic [4:0] REG_RA   = 5'd1;
  localparam logic [4:0] REG_SP   = 5'd2;
  localparam logic [4:0] REG_A0   = 5'd10;
  localparam logic [4:0] REG_A1   = 5'd11;

  ////////////////////
  // Helpers
  ////////////////////

  // Number of s-registers named by rlist, ra not included
  function automatic logic [3:0] pushpop_reg_length(input logic [3:0] rlist);
    logic [3:0] len;
    if (rlist == 4'd15) begin
      len = 4'd12;   // s10 alone is not encodable, so 15 saves s0-s11
    end else if (rlist > 4'd4) begin
      len = rlist - 4'd4;
    end else begin
      len = 4'd0;
    end
    return len;
  endfunction

  // s0 and s1 sit at x8/x9, s2 onwards start at x18
  function automatic logic [4:0] sn_to_regnum(input logic [4:0] sn);
    logic [4:0] num;
    if (sn < 5'd2) begin
      num = 5'd8 + sn;
    end else begin
      num = 5'd16 + sn;
    end
    return num;
  endfunction

  // Round a byte count up to the 16-byte stack alignment
  function automatic logic [11:0] align_16(input logic [11:0] bytes);
    return (bytes + 12'd15) & 12'hff0;
  endfunction

endpackage

// File: source/fetch_slot_if.sv
`timescale 1ns/10ps

interface fetch_slot_if;
  import zc_seq_pkg::*;

  instr_word_t word;
  logic        is_ptr;
  logic        full;
  logic        consume;

  modport slot (
    output word,
    output is_ptr,
    output full,
    input  consume
  );

  modport seq (
    input  word,
    input  is_ptr,
    input  full,
    output consume
  );

endinterface

// File: source/seq_issue_if.sv
`timescale 1ns/10ps

interface seq_issue_if;
  import zc_seq_pkg::*;

  instr_word_t instr;
  logic        valid;
  logic        last;
  logic        illegal;
  logic        accepted;

  modport seq (
    output instr,
    output valid,
    output last,
    output illegal,
    input  accepted
  );

  modport issue (
    input  instr,
    input  valid,
    input  last,
    input  illegal,
    output accepted
  );

endinterface

// File: source/fetch_slot.sv
`timescale 1ns/10ps

module fetch_slot (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    fetch_valid_i,
  input  zc_seq_pkg::instr_word_t fetch_word_i,
  input  logic                    fetch_is_ptr_i,
  input  logic                    kill_i,
  output logic                    fetch_ready_o,
  fetch_slot_if.slot              slot_o
);
  import zc_seq_pkg::*;

  logic        full_q;
  logic        take;
  instr_word_t word_q;
  logic        is_ptr_q;

  // Refill is allowed on the same edge the current word leaves
  assign fetch_ready_o = !kill_i && (!full_q || slot_o.consume);
  assign take          = fetch_valid_i && fetch_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full_q <= 1'b0;
    end else if (kill_i) begin
      full_q <= 1'b0;
    end else if (take) begin
      full_q <= 1'b1;
    end else if (slot_o.consume) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      word_q   <= fetch_word_i;
      is_ptr_q <= fetch_is_ptr_i;
    end
  end

  assign slot_o.word   = word_q;
  assign slot_o.is_ptr = is_ptr_q;
  assign slot_o.full   = full_q;

  // A held word only leaves through the sequencer or a flush
  a_full_held: assert property (@(posedge clk) disable iff (!rst_n)
    full_q && !slot_o.consume && !kill_i |=> full_q);

endmodule

// File: source/cm_sequencer.sv
`timescale 1ns/10ps

module cm_sequencer (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      kill_i,
  fetch_slot_if.seq slot_i,
  seq_issue_if.seq  issue_o
);
  import zc_seq_pkg::*;

  instr_word_t word;
  logic [3:0]  rlist;
  seq_instr_e  seq_instr;
  logic        illegal;
  logic        is_store;
  logic        is_load;
  logic        is_move;

  logic [3:0]  n_saved;
  logic [11:0] reg_adj;
  logic [11:0] total_adj;
  logic [11:0] step_off;
  logic [11:0] cur_off;
  logic [4:0]  sreg;

  logic [3:0]  cnt_q;
  seq_state_e  state_q;
  seq_state_e  state_n;
  seq_state_e  step;
  logic        fire;
  logic        last;
  instr_word_t instr;

  function automatic instr_word_t enc_lw(input logic [4:0] rd, input logic [11:0] off);
    return {off, REG_SP, 3'b010, rd, OPCODE_LOAD};
  endfunction

  function automatic instr_word_t enc_sw(input logic [4:0] rs2, input logic [11:0] off);
    return {off[11:5], rs2, REG_SP, 3'b010, off[4:0], OPCODE_STORE};
  endfunction

  function automatic instr_word_t enc_addi(input logic [4:0]  rd,
                                           input logic [4:0]  rs1,
                                           input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, OPCODE_OPIMM};
  endfunction

  assign word  = slot_i.word;
  assign rlist = word[7:4];

  ////////////////////
  // Decode
  ////////////////////

  // Pointer words are data for a table jump and never decode
  always_comb begin
    seq_instr = INVALID_INST;
    illegal   = 1'b0;
    if (!slot_i.is_ptr && word[1:0] == 2'b10 && word[15:13] == 3'b101) begin
      case (word[12:10])
        3'b011: begin
          if (word[6:5] == 2'b11) begin
            seq_instr = MVA01S;
          end else if (word[6:5] == 2'b01) begin
            seq_instr = MVSA01;
          end
        end
        3'b110: begin
          if (word[9:8] == 2'b00) begin
            if (rlist >= 4'd4) begin
              seq_instr = PUSH;
            end else begin
              illegal = 1'b1;
            end
          end else if (word[9:8] == 2'b10) begin
            seq_instr = POP;
          end
        end
        3'b111: begin
          if (word[9:8] == 2'b00) begin
            seq_instr = POPRETZ;
          end else if (word[9:8] == 2'b10) begin
            seq_instr = POPRET;
          end
        end
        default: begin
          seq_instr = INVALID_INST;
        end
      endcase
    end
  end

  assign is_store = (seq_instr == PUSH);
  assign is_load  = (seq_instr == POP) || (seq_instr == POPRET) || (seq_instr == POPRETZ);
  assign is_move  = (seq_instr == MVSA01) || (seq_instr == MVA01S);

  // Stack frame covers the s-registers plus ra, then spimm adds 16-byte blocks
  assign n_saved   = pushpop_reg_length(rlist);
  assign reg_adj   = align_16({6'd0, n_saved + 4'd1, 2'b00});
  assign total_adj = reg_adj + {6'd0, word[3:2], 4'd0};

  // Step k touches -(k+1)*4 from the old sp
  assign step_off = {6'd0, cnt_q, 2'b00} + 12'd4;
  assign cur_off  = is_store ? 12'd0 - step_off : total_adj - step_off;
  assign sreg     = {1'b0, n_saved - cnt_q - 4'd1};

  ////////////////////
  // Step selection
  ////////////////////

  // In S_IDLE the first step of a push/pop is already emitted
  always_comb begin
    step = state_q;
    if (state_q == S_IDLE) begin
      if (is_store) begin
        step = (n_saved != 4'd0) ? S_PUSH : S_RA;
      end else if (is_load) begin
        step = (n_saved != 4'd0) ? S_POP : S_RA;
      end
    end
  end

  always_comb begin
    instr   = word;
    last    = 1'b0;
    state_n = S_IDLE;
    case (step)
      S_IDLE: begin
        if (seq_instr == MVSA01) begin
          instr = enc_addi(sn_to_regnum({2'b00, word[9:7]}), REG_A0, 12'd0);
        end else if (seq_instr == MVA01S) begin
          instr = enc_addi(REG_A0, sn_to_regnum({2'b00, word[9:7]}), 12'd0);
        end else begin
          last = 1'b1;  // raw word, illegal push included
        end
        state_n = is_move ? S_DMOVE : S_IDLE;
      end
      S_PUSH: begin
        instr   = enc_sw(sn_to_regnum(sreg), cur_off);
        state_n = (cnt_q + 4'd1 == n_saved) ? S_RA : S_PUSH;
      end
      S_POP: begin
        instr   = enc_lw(sn_to_regnum(sreg), cur_off);
        state_n = (cnt_q + 4'd1 == n_saved) ? S_RA : S_POP;
      end
      S_RA: begin
        instr   = is_store ? enc_sw(REG_RA, cur_off) : enc_lw(REG_RA, cur_off);
        state_n = S_SP;
      end
      S_SP: begin
        instr = is_store ? enc_addi(REG_SP, REG_SP, 12'd0 - total_adj)
                         : enc_addi(REG_SP, REG_SP, total_adj);
        if (seq_instr == POPRETZ) begin
          state_n = S_A0;
        end else if (seq_instr == POPRET) begin
          state_n = S_RET;
        end else begin
          last = 1'b1;
        end
      end
      S_A0: begin
        instr   = enc_addi(REG_A0, REG_ZERO, 12'd0);
        state_n = S_RET;
      end
      S_RET: begin
        instr = {12'd0, REG_RA, 3'b000, REG_ZERO, OPCODE_JALR};
        last  = 1'b1;
      end
      S_DMOVE: begin
        // Second half of the pair goes through a1
        if (seq_instr == MVSA01) begin
          instr = enc_addi(sn_to_regnum({2'b00, word[4:2]}), REG_A1, 12'd0);
        end else begin
          instr = enc_addi(REG_A1, sn_to_regnum({2'b00, word[4:2]}), 12'd0);
        end
        last = 1'b1;
      end
      default: begin
        state_n = S_IDLE;
      end
    endcase
  end

  assign fire = issue_o.valid && issue_o.accepted;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      cnt_q   <= 4'd0;
    end else if (kill_i) begin
      state_q <= S_IDLE;
      cnt_q   <= 4'd0;
    end else if (fire) begin
      state_q <= state_n;
      cnt_q   <= last ? 4'd0 : cnt_q + 4'd1;
    end
  end

  assign issue_o.valid   = slot_i.full;
  assign issue_o.instr   = instr;
  assign issue_o.last    = last;
  assign issue_o.illegal = illegal;
  assign slot_i.consume  = fire && last;

  a_instr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    issue_o.valid && !issue_o.accepted && !kill_i |=> $stable(issue_o.instr));

  a_idle_after_last: assert property (@(posedge clk) disable iff (!rst_n)
    fire && last && !kill_i |=> state_q == S_IDLE && cnt_q == 4'd0);

endmodule

// File: source/issue_reg.sv
`timescale 1ns/10ps

module issue_reg (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    stall_i,
  input  logic                    kill_i,
  seq_issue_if.issue              issue_i,
  output logic                    issue_valid_o,
  output zc_seq_pkg::instr_word_t issue_instr_o,
  output logic                    issue_illegal_o,
  output logic                    issue_last_o
);
  import zc_seq_pkg::*;

  logic        valid_q;
  instr_word_t instr_q;
  logic        illegal_q;
  logic        last_q;

  // An empty register takes a step even while downstream stalls
  assign issue_i.accepted = !valid_q || !stall_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (kill_i) begin
      valid_q <= 1'b0;
    end else if (issue_i.accepted) begin
      valid_q <= issue_i.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_i.accepted && issue_i.valid) begin
      instr_q   <= issue_i.instr;
      illegal_q <= issue_i.illegal;
      last_q    <= issue_i.last;
    end
  end

  assign issue_valid_o   = valid_q;
  assign issue_instr_o   = instr_q;
  assign issue_illegal_o = illegal_q;
  assign issue_last_o    = last_q;

  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    issue_valid_o && stall_i && !kill_i |=> issue_valid_o && $stable(issue_instr_o)
      && $stable(issue_illegal_o) && $stable(issue_last_o));

endmodule

// File: source/zc_issue_top.sv
`timescale 1ns/10ps

module zc_issue_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    fetch_valid_i,
  input  zc_seq_pkg::instr_word_t fetch_word_i,
  input  logic                    fetch_is_ptr_i,
  output logic                    fetch_ready_o,
  input  logic                    stall_i,
  input  logic                    kill_i,
  output logic                    issue_valid_o,
  output zc_seq_pkg::instr_word_t issue_instr_o,
  output logic                    issue_illegal_o,
  output logic                    issue_last_o
);

  fetch_slot_if slot_bus ();
  seq_issue_if  issue_bus ();

  // Prefetched words wait here until fully expanded
  fetch_slot u_fetch_slot (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_word_i   (fetch_word_i),
    .fetch_is_ptr_i (fetch_is_ptr_i),
    .kill_i         (kill_i),
    .fetch_ready_o  (fetch_ready_o),
    .slot_o         (slot_bus.slot)
  );

  cm_sequencer u_cm_sequencer (
    .clk     (clk),
    .rst_n   (rst_n),
    .kill_i  (kill_i),
    .slot_i  (slot_bus.seq),
    .issue_o (issue_bus.seq)
  );

  // Stands in for the decode stage
  issue_reg u_issue_reg (
    .clk             (clk),
    .rst_n           (rst_n),
    .stall_i         (stall_i),
    .kill_i          (kill_i),
    .issue_i         (issue_bus.issue),
    .issue_valid_o   (issue_valid_o),
    .issue_instr_o   (issue_instr_o),
    .issue_illegal_o (issue_illegal_o),
    .issue_last_o    (issue_last_o)
  );

endmodule

// File: bench/zc_expand_model.svh
`ifndef ZC_EXPAND_MODEL_SVH
`define ZC_EXPAND_MODEL_SVH

// One expected issue step
typedef struct packed {
  instr_word_t instr;
  logic        illegal;
  logic        last;
} step_t;

typedef step_t step_q_t[$];

////////////////////
// RV32I encoders
////////////////////

function automatic instr_word_t itype(input logic [6:0]  op,
                                      input logic [2:0]  f3,
                                      input logic [4:0]  rd,
                                      input logic [4:0]  rs1,
                                      input logic [11:0] imm);
  return {imm, rs1, f3, rd, op};
endfunction

// sw rs2, off(sp)
function automatic instr_word_t store_sp(input logic [4:0] rs2, input logic [11:0] off);
  return {off[11:5], rs2, REG_SP, 3'b010, off[4:0], OPCODE_STORE};
endfunction

function automatic step_t make_step(input instr_word_t i, input logic ill, input logic l);
  step_t s;
  s.instr   = i;
  s.illegal = ill;
  s.last    = l;
  return s;
endfunction

////////////////////
// Reference expansion
////////////////////

function automatic step_q_t zc_expand(input instr_word_t w, input logic is_ptr);
  step_q_t     q;
  seq_instr_e  kind;
  logic        bad_push;
  int          ns;
  logic [11:0] frame;
  logic [4:0]  r1;
  logic [4:0]  r2;
  kind     = INVALID_INST;
  bad_push = 1'b0;
  ns       = int'(pushpop_reg_length(w[7:4]));
  // Save area of s-regs plus ra rounds up to 16 bytes, spimm adds 16-byte blocks
  frame    = align_16(12'(4 * (ns + 1))) + 12'(16 * int'(w[3:2]));
  r1       = sn_to_regnum({2'b00, w[9:7]});
  r2       = sn_to_regnum({2'b00, w[4:2]});
  if (!is_ptr && w[1:0] == 2'b10 && w[15:13] == 3'b101) begin
    case (w[12:8])
      5'b11000: begin
        if (w[7:4] < 4'd4) begin
          bad_push = 1'b1;
        end else begin
          kind = PUSH;
        end
      end
      5'b11010: kind = POP;
      5'b11100: kind = POPRETZ;
      5'b11110: kind = POPRET;
      default: begin
        if (w[12:10] == 3'b011 && w[6:5] == 2'b01) begin
          kind = MVSA01;
        end else if (w[12:10] == 3'b011 && w[6:5] == 2'b11) begin
          kind = MVA01S;
        end
      end
    endcase
  end
  case (kind)
    MVSA01: begin
      q.push_back(make_step(itype(OPCODE_OPIMM, 3'b000, r1, REG_A0, 12'd0), 1'b0, 1'b0));
      q.push_back(make_step(itype(OPCODE_OPIMM, 3'b000, r2, REG_A1, 12'd0), 1'b0, 1'b1));
    end
    MVA01S: begin
      q.push_back(make_step(itype(OPCODE_OPIMM, 3'b000, REG_A0, r1, 12'd0), 1'b0, 1'b0));
      q.push_back(make_step(itype(OPCODE_OPIMM, 3'b000, REG_A1, r2, 12'd0), 1'b0, 1'b1));
    end
    PUSH: begin
      // Highest s-register goes just below the old sp
      for (int k = 0; k < ns; k++) begin
        q.push_back(make_step(store_sp(sn_to_regnum(5'(ns - 1 - k)),
                                       12'd0 - 12'(4 * (k + 1))), 1'b0, 1'b0));
      end
      q.push_back(make_step(store_sp(REG_RA, 12'd0 - 12'(4 * (ns + 1))), 1'b0, 1'b0));
      q.push_back(make_step(itype(OPCODE_OPIMM, 3'b000, REG_SP, REG_SP, 12'd0 - frame),
                            1'b0, 1'b1));
    end
    POP, POPRET, POPRETZ: begin
      for (int k = 0; k < ns; k++) begin
        q.push_back(make_step(itype(OPCODE_LOAD, 3'b010, sn_to_regnum(5'(ns - 1 - k)), REG_SP,
                                    frame - 12'(4 * (k + 1))), 1'b0, 1'b0));
      end
      q.push_back(make_step(itype(OPCODE_LOAD, 3'b010, REG_RA, REG_SP,
                                  frame - 12'(4 * (ns + 1))), 1'b0, 1'b0));
      q.push_back(make_step(itype(OPCODE_OPIMM, 3'b000, REG_SP, REG_SP, frame),
                            1'b0, kind == POP));
      if (kind == POPRETZ) begin
        q.push_back(make_step(itype(OPCODE_OPIMM, 3'b000, REG_A0, REG_ZERO, 12'd0), 1'b0, 1'b0));
      end
      if (kind != POP) begin
        q.push_back(make_step(itype(OPCODE_JALR, 3'b000, REG_ZERO, REG_RA, 12'd0), 1'b0, 1'b1));
      end
    end
    default: begin
      q.push_back(make_step(w, bad_push, 1'b1));
    end
  endcase
  return q;
endfunction

// Galois LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

////////////////////
// Compare tasks
////////////////////

task automatic check_instr(input string name, input instr_word_t got,
                           input instr_word_t exp, inout int errs);
  if (got !== exp) begin
    $display("Fail %s: got %h, expected %h", name, got, exp);
    errs++;
  end
endtask

task automatic check_flag(input string name, input logic got, input logic exp, inout int errs);
  if (got !== exp) begin
    $display("Fail %s: got %h, expected %h", name, got, exp);
    errs++;
  end
endtask

`endif

// File: bench/tb_zc_issue.sv
`timescale 1ns/10ps

module tb_zc_issue;
  import zc_seq_pkg::*;

  localparam logic [4:0] OP_PUSH    = 5'b11000;
  localparam logic [4:0] OP_POP     = 5'b11010;
  localparam logic [4:0] OP_POPRETZ = 5'b11100;
  localparam logic [4:0] OP_POPRET  = 5'b11110;

  // push 48, pops 144, moves 128, pass-through 16, random 200, kill 2
  localparam int N_RANDOM        = 200;
  localparam int N_WORDS         = 48 + 144 + 128 + 16 + N_RANDOM + 2;
  localparam int WATCHDOG_CYCLES = 40 * N_WORDS + 200;

  logic        clk;
  logic        rst_n;
  logic        fetch_valid_i;
  instr_word_t fetch_word_i;
  logic        fetch_is_ptr_i;
  logic        fetch_ready_o;
  logic        stall_i;
  logic        kill_i;
  logic        issue_valid_o;
  instr_word_t issue_instr_o;
  logic        issue_illegal_o;
  logic        issue_last_o;

  int          errors = 0;
  int          stim_errors = 0;
  int          checks = 0;
  logic [31:0] lfsr;
  logic        stall_en;

  `include "zc_expand_model.svh"

  step_t exp_q[$];

  zc_issue_top DUT (
    .clk             (clk),
    .rst_n           (rst_n),
    .fetch_valid_i   (fetch_valid_i),
    .fetch_word_i    (fetch_word_i),
    .fetch_is_ptr_i  (fetch_is_ptr_i),
    .fetch_ready_o   (fetch_ready_o),
    .stall_i         (stall_i),
    .kill_i          (kill_i),
    .issue_valid_o   (issue_valid_o),
    .issue_instr_o   (issue_instr_o),
    .issue_illegal_o (issue_illegal_o),
    .issue_last_o    (issue_last_o)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20;
      clk = ~clk;
    end
  end

  ////////////////////
  // Stimulus helpers
  ////////////////////

  function automatic logic [31:0] take_bits(input int nbits);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic instr_word_t pushpop_word(input logic [4:0] op, input logic [3:0] rlist,
                                               input logic [1:0] spimm);
    return {16'h0, 3'b101, op, rlist, spimm, 2'b10};
  endfunction

  function automatic instr_word_t move_word(input logic [2:0] r1, input logic to_a,
                                            input logic [2:0] r2);
    return {16'h0, 6'b101011, r1, (to_a ? 2'b11 : 2'b01), r2, 2'b10};
  endfunction

  // Every cycle starts at the falling edge where stall is redrawn
  task automatic tick();
    @(negedge clk);
    stall_i = stall_en ? (take_bits(2) == 32'd0) : 1'b0;
  endtask

  task automatic offer_word(input instr_word_t w, input logic ptr);
    step_q_t steps;
    steps = zc_expand(w, ptr);
    tick();
    fetch_valid_i  = 1'b1;
    fetch_word_i   = w;
    fetch_is_ptr_i = ptr;
    foreach (steps[i]) begin
      exp_q.push_back(steps[i]);
    end
    @(posedge clk);
    while (!fetch_ready_o) begin
      tick();
      @(posedge clk);
    end
  endtask

  task automatic random_word(output instr_word_t w, output logic ptr);
    logic [2:0]  sel;
    logic [15:0] f;
    sel = 3'(take_bits(3));
    f   = 16'(take_bits(16));
    ptr = 1'b0;
    case (sel)
      3'd0: w = pushpop_word(OP_PUSH, f[3:0], f[5:4]);
      3'd1: w = pushpop_word(OP_POP, f[3:0], f[5:4]);
      3'd2: w = pushpop_word(OP_POPRET, f[3:0], f[5:4]);
      3'd3: w = pushpop_word(OP_POPRETZ, f[3:0], f[5:4]);
      3'd4: w = move_word(f[8:6], f[12], f[11:9]);
      3'd5: w = take_bits(32) | 32'h3;
      3'd6: w = {16'h0, f[15:2], 2'b10};  // a quadrant 2 word that may hit Zcmp or miss it
      default: begin
        w   = take_bits(32);
        ptr = 1'b1;
      end
    endcase
  endtask

  task automatic finish_test(input string name);
    tick();
    fetch_valid_i = 1'b0;
    while (exp_q.size() != 0) begin
      tick();
    end
    // Stray steps would reach the checker here
    repeat (4) tick();
    $display("Test %0s finished: %0d steps checked, %0d errors", name, checks,
             errors + stim_errors);
  endtask

  ////////////////////
  // Checker
  ////////////////////

  always @(posedge clk) begin : compare_steps
    step_t e;
    if (rst_n && issue_valid_o && !stall_i) begin
      if (exp_q.size() == 0) begin
        $display("Step %h was issued while no step was expected", issue_instr_o);
        errors++;
      end else begin
        e = exp_q.pop_front();
        check_instr("issue_instr_o", issue_instr_o, e.instr, errors);
        check_flag("issue_illegal_o", issue_illegal_o, e.illegal, errors);
        check_flag("issue_last_o", issue_last_o, e.last, errors);
        checks++;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin : main
    instr_word_t w;
    logic        ptr;
    int          base;
    int          dropped;
    rst_n          = 1'b0;
    fetch_valid_i  = 1'b0;
    fetch_word_i   = '0;
    fetch_is_ptr_i = 1'b0;
    stall_i        = 1'b0;
    kill_i         = 1'b0;
    stall_en       = 1'b0;
    lfsr           = 32'h782e9212;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    tick();
    check_flag("fetch_ready_o", fetch_ready_o, 1'b1, stim_errors);
    check_flag("issue_valid_o", issue_valid_o, 1'b0, stim_errors);

    for (int rl = 4; rl < 16; rl++) begin
      for (int sp = 0; sp < 4; sp++) begin
        offer_word(pushpop_word(OP_PUSH, 4'(rl), 2'(sp)), 1'b0);
      end
    end
    finish_test("push");

    for (int rl = 4; rl < 16; rl++) begin
      for (int sp = 0; sp < 4; sp++) begin
        offer_word(pushpop_word(OP_POP, 4'(rl), 2'(sp)), 1'b0);
        offer_word(pushpop_word(OP_POPRET, 4'(rl), 2'(sp)), 1'b0);
        offer_word(pushpop_word(OP_POPRETZ, 4'(rl), 2'(sp)), 1'b0);
      end
    end
    finish_test("pop");

    for (int a = 0; a < 8; a++) begin
      for (int b = 0; b < 8; b++) begin
        offer_word(move_word(3'(a), 1'b0, 3'(b)), 1'b0);
        offer_word(move_word(3'(a), 1'b1, 3'(b)), 1'b0);
      end
    end
    finish_test("move");

    // Illegal pushes, pointer words, 32-bit words, near misses
    for (int i = 0; i < 4; i++) begin
      offer_word(pushpop_word(OP_PUSH, 4'(i), 2'(i)), 1'b0);
      offer_word(pushpop_word(OP_PUSH, 4'(i + 12), 2'(i)), 1'b1);
      offer_word(take_bits(32) | 32'h3, 1'b0);
    end
    offer_word(32'h0000_4505, 1'b0);
    offer_word(32'h0000_8082, 1'b0);
    offer_word(32'h0000_ae06, 1'b0);
    offer_word(32'h0000_b902, 1'b0);
    finish_test("pass-through");

    stall_en = 1'b1;
    for (int i = 0; i < N_RANDOM; i++) begin
      random_word(w, ptr);
      offer_word(w, ptr);
    end
    finish_test("random");
    stall_en = 1'b0;

    // Kill a long push after a few steps have left
    base = checks;
    offer_word(pushpop_word(OP_PUSH, 4'd15, 2'd3), 1'b0);
    tick();
    fetch_valid_i = 1'b0;
    while (checks < base + 5) begin
      tick();
    end
    kill_i = 1'b1;
    tick();
    kill_i  = 1'b0;
    dropped = exp_q.size();
    exp_q.delete();
    if (dropped == 0) begin
      $display("Kill pulse came after the whole sequence had issued");
      stim_errors++;
    end
    // Flushed state as seen at the next edge
    @(posedge clk);
    check_flag("issue_valid_o", issue_valid_o, 1'b0, stim_errors);
    check_flag("fetch_ready_o", fetch_ready_o, 1'b1, stim_errors);
    offer_word(pushpop_word(OP_POPRETZ, 4'd7, 2'd1), 1'b0);
    finish_test("kill");

    $display("Steps checked: %0d, errors: %0d", checks, errors + stim_errors);
    if (errors + stim_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: zc_issue_top.f
+incdir+bench
source/zc_seq_pkg.sv
source/fetch_slot_if.sv
source/seq_issue_if.sv
source/fetch_slot.sv
source/cm_sequencer.sv
source/issue_reg.sv
source/zc_issue_top.sv
bench/tb_zc_issue.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_zc_issue -f zc_issue_top.f

out=$(./obj_dir/Vtb_zc_issue 2>&1) || {
  printf '%s\n' "$out"
  exit 1
}
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'RESULT: PASS'
